//--- logic/imc_controller.sv
`timescale 1ns/1ps

module imc_controller
    import imc_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      start_i,    // single cycle strobe
    output imc_ctrl_t ctrl_o,     // moore, straight from state
    output logic      ready_o     // level, high in READY
);

    imc_state_t state_q;
    imc_state_t state_d;

    // --------------------------------------------------
    // state register
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            state_q <= ST_RESET;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // next state, start only honoured when idle
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_RESET: state_d = start_i ? ST_START : ST_RESET;
            ST_START: state_d = ST_DET;
            ST_DET:   state_d = ST_TERM;
            ST_TERM:  state_d = ST_MAT_1;
            ST_MAT_1: state_d = ST_MAT_2;
            ST_MAT_2: state_d = ST_READY;
            ST_READY: state_d = start_i ? ST_START : ST_READY;
            default:  state_d = ST_RESET;   // unused encoding
        endcase
    end

    // --------------------------------------------------
    // control word decode
    // --------------------------------------------------
    always_comb
    begin
        ctrl_o = '0;    // everything idle by default
        case (state_q)
            ST_START:
            begin
                // sel_* stay 0, elements come from ports
                ctrl_o.en_a = 1'b1;
                ctrl_o.en_b = 1'b1;
                ctrl_o.en_c = 1'b1;
                ctrl_o.en_d = 1'b1;
            end
            ST_DET:
            begin
                ctrl_o.en_det    = 1'b1;    // mul operands b become a, c
                ctrl_o.sel_mul_1 = 1'b1;    // mul_1 = b*c, mul_0 = d*a
            end
            ST_TERM:
            begin
                ctrl_o.en_term = 1'b1;      // recip output captured
            end
            ST_MAT_1:
            begin
                ctrl_o.en_a  = 1'b1;
                ctrl_o.en_d  = 1'b1;
                ctrl_o.sel_a = 1'b1;        // d*term
                ctrl_o.sel_d = 1'b1;        // a*term
            end
            ST_MAT_2:
            begin
                ctrl_o.en_b      = 1'b1;
                ctrl_o.en_c      = 1'b1;
                ctrl_o.sel_b     = 1'b1;
                ctrl_o.sel_c     = 1'b1;
                ctrl_o.sel_mul_0 = 1'b1;    // c*term
                ctrl_o.sel_mul_1 = 1'b1;    // b*term
                ctrl_o.neg_b     = 1'b1;
                ctrl_o.neg_c     = 1'b1;
            end
            default:
            begin
                ctrl_o = '0;    // RESET and READY just hold
            end
        endcase
    end

    assign ready_o = (state_q == ST_READY);

endmodule

//--- logic/imc_datapath.sv
`timescale 1ns/1ps

module imc_datapath
    import imc_pkg::*;
#(
    parameter int DATA_W = 16,
    parameter int FRAC_W = 8
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  imc_ctrl_t         ctrl_i,
    input  logic [DATA_W-1:0] a_i,
    input  logic [DATA_W-1:0] b_i,
    input  logic [DATA_W-1:0] c_i,
    input  logic [DATA_W-1:0] d_i,
    input  logic [DATA_W-1:0] term_i,       // from recip, comb
    input  logic              singular_i,   // from recip, comb
    output logic [DATA_W-1:0] a_o,
    output logic [DATA_W-1:0] b_o,
    output logic [DATA_W-1:0] c_o,
    output logic [DATA_W-1:0] d_o,
    output logic [DATA_W-1:0] det_o,
    output logic              singular_o
);

    logic [DATA_W-1:0] a_q, b_q, c_q, d_q;
    logic [DATA_W-1:0] det_q, term_q;
    logic              sing_q;

    logic signed [DATA_W-1:0]   mul0_x, mul0_y;
    logic signed [DATA_W-1:0]   mul1_x, mul1_y;
    logic signed [2*DATA_W-1:0] mul0_full, mul1_full;
    logic signed [2*DATA_W-1:0] det_full;
    logic [DATA_W-1:0]          mul0_s, mul1_s;     // scaled, wrapped
    logic [DATA_W-1:0]          det_nxt;
    logic [DATA_W-1:0]          a_nxt, b_nxt, c_nxt, d_nxt;
    logic [DATA_W-1:0]          b_sel, c_sel;

    // --------------------------------------------------
    // shared multipliers
    // --------------------------------------------------
    // operand a from sel_mul_*, operand b is the det partner in DET else term
    assign mul0_x = ctrl_i.sel_mul_0 ? c_q : d_q;
    assign mul0_y = ctrl_i.en_det    ? a_q : term_q;
    assign mul1_x = ctrl_i.sel_mul_1 ? b_q : a_q;
    assign mul1_y = ctrl_i.en_det    ? c_q : term_q;

    assign mul0_full = (2*DATA_W)'(mul0_x) * (2*DATA_W)'(mul0_y);     // full 2*DATA_W product
    assign mul1_full = (2*DATA_W)'(mul1_x) * (2*DATA_W)'(mul1_y);

    // asr by FRAC_W then keep DATA_W bits
    assign mul0_s = mul0_full[FRAC_W +: DATA_W];
    assign mul1_s = mul1_full[FRAC_W +: DATA_W];

    // det from the full products, same shift/truncate
    assign det_full = mul0_full - mul1_full;
    assign det_nxt  = det_full[FRAC_W +: DATA_W];

    // --------------------------------------------------
    // write-back muxes
    // --------------------------------------------------
    assign b_sel = ctrl_i.sel_b ? mul1_s : b_i;
    assign c_sel = ctrl_i.sel_c ? mul0_s : c_i;

    assign a_nxt = ctrl_i.sel_a ? mul0_s : a_i;
    assign d_nxt = ctrl_i.sel_d ? mul1_s : d_i;
    assign b_nxt = ctrl_i.neg_b ? DATA_W'(-b_sel) : b_sel;    // wraps
    assign c_nxt = ctrl_i.neg_c ? DATA_W'(-c_sel) : c_sel;

    // --------------------------------------------------
    // registers
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            a_q    <= '0;
            b_q    <= '0;
            c_q    <= '0;
            d_q    <= '0;
            det_q  <= '0;
            term_q <= '0;
            sing_q <= 1'b0;
        end
        else
        begin
            if (ctrl_i.en_a)
                a_q <= a_nxt;
            if (ctrl_i.en_b)
                b_q <= b_nxt;
            if (ctrl_i.en_c)
                c_q <= c_nxt;
            if (ctrl_i.en_d)
                d_q <= d_nxt;
            if (ctrl_i.en_det)
                det_q <= det_nxt;
            if (ctrl_i.en_term)
            begin
                term_q <= term_i;
                sing_q <= singular_i;   // flag travels with term
            end
        end
    end

    assign a_o        = a_q;
    assign b_o        = b_q;
    assign c_o        = c_q;
    assign d_o        = d_q;
    assign det_o      = det_q;
    assign singular_o = sing_q;

endmodule

//--- logic/imc_pkg.sv
package imc_pkg;

    // --------------------------------------------------
    // controller states, one per cycle of the sequence
    // --------------------------------------------------
    typedef enum logic [2:0]
    {
        ST_RESET = 3'd0,    // idle after reset
        ST_START = 3'd1,    // load a..d from the ports
        ST_DET   = 3'd2,    // a*d - b*c into det
        ST_TERM  = 3'd3,    // 1/det into term
        ST_MAT_1 = 3'd4,    // a <- d*term, d <- a*term
        ST_MAT_2 = 3'd5,    // b <- -b*term, c <- -c*term
        ST_READY = 3'd6     // result held
    } imc_state_t;

    // --------------------------------------------------
    // control word, controller -> datapath
    // --------------------------------------------------
    typedef struct packed
    {
        logic en_a;         // element reg enables
        logic en_b;
        logic en_c;
        logic en_d;
        logic en_det;       // det reg enable, also steers mul operand b
        logic en_term;      // term + singular reg enable
        logic neg_b;        // negate b write-back
        logic neg_c;        // negate c write-back
        logic sel_a;        // 0: a_i, 1: mul_0
        logic sel_b;        // 0: b_i, 1: mul_1
        logic sel_c;        // 0: c_i, 1: mul_0
        logic sel_d;        // 0: d_i, 1: mul_1
        logic sel_mul_0;    // mul_0 operand a: 0: d, 1: c
        logic sel_mul_1;    // mul_1 operand a: 0: a, 1: b
    } imc_ctrl_t;

endpackage

//--- logic/imc_recip.sv
`timescale 1ns/1ps

module imc_recip #(
    parameter int DATA_W = 16,
    parameter int FRAC_W = 8
) (
    input  logic [DATA_W-1:0] det_i,
    output logic [DATA_W-1:0] term_o,
    output logic              singular_o
);

    // wide enough for 2^(2*FRAC_W) and a sign extended det
    localparam int QW = 2 * FRAC_W + DATA_W + 1;

    localparam logic signed [QW-1:0] ONE_SQ = {{(QW-1){1'b0}}, 1'b1} << (2 * FRAC_W);
    localparam logic signed [QW-1:0] Q_MAX  = {{(QW-DATA_W+1){1'b0}}, {(DATA_W-1){1'b1}}};
    localparam logic signed [QW-1:0] Q_MIN  = {{(QW-DATA_W+1){1'b1}}, {(DATA_W-1){1'b0}}};

    logic signed [QW-1:0] det_ext;
    logic signed [QW-1:0] divisor;
    logic signed [QW-1:0] quot;
    logic [DATA_W-1:0]    quot_sat;

    assign det_ext    = {{(QW-DATA_W){det_i[DATA_W-1]}}, det_i};
    assign singular_o = (det_i == '0);

    // divide by one when singular so the quotient never goes x
    assign divisor = singular_o ? {{(QW-1){1'b0}}, 1'b1} : det_ext;
    assign quot    = ONE_SQ / divisor;     // signed, truncates toward zero

    // clamp to the element range
    always_comb
    begin
        if (quot > Q_MAX)
        begin
            quot_sat = Q_MAX[DATA_W-1:0];
        end
        else if (quot < Q_MIN)
        begin
            quot_sat = Q_MIN[DATA_W-1:0];
        end
        else
        begin
            quot_sat = quot[DATA_W-1:0];
        end
    end

    assign term_o = singular_o ? '0 : quot_sat;    // singular forces zero

endmodule

//--- logic/imc_top.sv
`timescale 1ns/1ps

module imc_top
    import imc_pkg::*;
#(
    parameter int DATA_W = 16,
    parameter int FRAC_W = 8
) (
    input  logic              clk_i,
    input  logic              rstn_i,
    input  logic              start_i,
    input  logic [DATA_W-1:0] a_i,
    input  logic [DATA_W-1:0] b_i,
    input  logic [DATA_W-1:0] c_i,
    input  logic [DATA_W-1:0] d_i,
    output logic [DATA_W-1:0] a_o,
    output logic [DATA_W-1:0] b_o,
    output logic [DATA_W-1:0] c_o,
    output logic [DATA_W-1:0] d_o,
    output logic              singular_o,
    output logic              ready_o
);

    imc_ctrl_t         ctrl;
    logic [DATA_W-1:0] det;
    logic [DATA_W-1:0] term;
    logic              singular;   // comb, before the register

    // --------------------------------------------------
    // sequencer
    // --------------------------------------------------
    imc_controller u_ctrl (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .start_i (start_i),
        .ctrl_o  (ctrl),
        .ready_o (ready_o)
    );

    // element, det and term storage
    imc_datapath #(
        .DATA_W (DATA_W),
        .FRAC_W (FRAC_W)
    ) u_dp (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .ctrl_i     (ctrl),
        .a_i        (a_i),
        .b_i        (b_i),
        .c_i        (c_i),
        .d_i        (d_i),
        .term_i     (term),
        .singular_i (singular),
        .a_o        (a_o),
        .b_o        (b_o),
        .c_o        (c_o),
        .d_o        (d_o),
        .det_o      (det),
        .singular_o (singular_o)
    );

    // 1/det, purely combinational
    imc_recip #(
        .DATA_W (DATA_W),
        .FRAC_W (FRAC_W)
    ) u_recip (
        .det_i      (det),
        .term_o     (term),
        .singular_o (singular)
    );

endmodule

//--- run.sh
#!/bin/sh
# build and run the imc testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module imc_tb -f src.f -o imc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/imc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0

//--- src.f
logic/imc_pkg.sv
logic/imc_controller.sv
logic/imc_recip.sv
logic/imc_datapath.sv
logic/imc_top.sv
test/imc_tb.sv

//--- test/imc_tb.sv
`timescale 1ns/1ps

module imc_tb;

    localparam int DATA_W  = 16;
    localparam int FRAC_W  = 8;
    localparam int N_FIXED = 10;
    localparam int N_RAND  = 8;
    localparam int N_ROWS  = N_FIXED + N_RAND;
    localparam int LATENCY = 5;                   // READY entered at edge k+5
    localparam int LIMIT   = N_ROWS * 10 + 50;    // cycles, reset included

    typedef struct packed
    {
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] c;
        logic [DATA_W-1:0] d;
        logic              sing;        // expected singular flag
        logic              mid_start;   // extra strobe while busy
    } row_t;

    logic              clk_i;
    logic              rstn_i;
    logic              start_i;
    logic [DATA_W-1:0] a_i, b_i, c_i, d_i;
    logic [DATA_W-1:0] a_o, b_o, c_o, d_o;
    logic              singular_o;
    logic              ready_o;

    row_t tbl [N_ROWS];
    int   seed = 59;
    int   row_errs;
    int   pass_cnt;
    int   fail_cnt;
    int   cycles;

    imc_top #(
        .DATA_W (DATA_W),
        .FRAC_W (FRAC_W)
    ) DUT (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .start_i    (start_i),
        .a_i        (a_i),
        .b_i        (b_i),
        .c_i        (c_i),
        .d_i        (d_i),
        .a_o        (a_o),
        .b_o        (b_o),
        .c_o        (c_o),
        .d_o        (d_o),
        .singular_o (singular_o),
        .ready_o    (ready_o)
    );

    // --------------------------------------------------
    // reference arithmetic
    // --------------------------------------------------
    // full product, floor shift, wrap to DATA_W
    function automatic logic [DATA_W-1:0] fx_mul(input logic [DATA_W-1:0] x,
                                                 input logic [DATA_W-1:0] y);
        longint full;
        full = longint'($signed(x)) * longint'($signed(y));
        full = full >>> FRAC_W;
        return full[DATA_W-1:0];
    endfunction

    // 2^(2F)/det toward zero, clamped, zero when singular
    function automatic logic [DATA_W-1:0] fx_recip(input logic [DATA_W-1:0] det);
        longint q;
        longint hi;
        longint lo;
        hi = (longint'(1) << (DATA_W - 1)) - 1;
        lo = -(longint'(1) << (DATA_W - 1));
        if (det == '0)
            return '0;
        q = (longint'(1) << (2 * FRAC_W)) / longint'($signed(det));
        if (q > hi)
            q = hi;
        else if (q < lo)
            q = lo;
        return q[DATA_W-1:0];
    endfunction

    task automatic compute_inverse(input row_t r, output logic [DATA_W-1:0] ea,
                                   output logic [DATA_W-1:0] eb,
                                   output logic [DATA_W-1:0] ec,
                                   output logic [DATA_W-1:0] ed, output logic es);
        longint            diff;
        logic [DATA_W-1:0] det;
        logic [DATA_W-1:0] term;
        diff = longint'($signed(r.a)) * longint'($signed(r.d))
             - longint'($signed(r.b)) * longint'($signed(r.c));
        diff = diff >>> FRAC_W;
        det  = diff[DATA_W-1:0];    // same floor + wrap as a product
        term = fx_recip(det);
        es   = (det == '0);
        ea   = fx_mul(r.d, term);
        ed   = fx_mul(r.a, term);
        eb   = -fx_mul(r.b, term);  // wraps in DATA_W
        ec   = -fx_mul(r.c, term);
    endtask

    function automatic row_t mk_row(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                                    input logic [DATA_W-1:0] c, input logic [DATA_W-1:0] d,
                                    input logic sing, input logic mid);
        row_t r;
        r.a         = a;
        r.b         = b;
        r.c         = c;
        r.d         = d;
        r.sing      = sing;
        r.mid_start = mid;
        return r;
    endfunction

    task automatic build_table();
        logic [DATA_W-1:0] ea, eb, ec, ed;
        logic              es;
        tbl[0] = mk_row(16'h0100, 16'h0000, 16'h0000, 16'h0100, 1'b0, 1'b0);  // identity
        tbl[1] = mk_row(16'h0200, 16'h0000, 16'h0000, 16'h0080, 1'b0, 1'b1);  // diag 2, 0.5
        tbl[2] = mk_row(16'h0000, 16'h0100, 16'h0100, 16'h0000, 1'b0, 1'b0);  // swap
        tbl[3] = mk_row(16'hff00, 16'h0000, 16'h0000, 16'hff00, 1'b0, 1'b0);  // -identity
        tbl[4] = mk_row(16'hfe00, 16'h0000, 16'h0000, 16'h0080, 1'b0, 1'b0);  // diag -2, 0.5
        tbl[5] = mk_row(16'h0100, 16'h0200, 16'h0080, 16'h0100, 1'b1, 1'b0);  // rank one
        tbl[6] = mk_row(16'h0000, 16'h0000, 16'h0000, 16'h0000, 1'b1, 1'b0);  // all zero
        tbl[7] = mk_row(16'h0001, 16'h0000, 16'h0000, 16'h0100, 1'b0, 1'b1);  // term -> max
        tbl[8] = mk_row(16'hfff0, 16'h0000, 16'h0000, 16'h0010, 1'b0, 1'b0);  // term -> min
        tbl[9] = mk_row(16'h0101, 16'h0100, 16'h0100, 16'h0100, 1'b0, 1'b0);  // wrapped d
        for (int i = N_FIXED; i < N_ROWS; i++)
        begin
            tbl[i] = mk_row(DATA_W'($random(seed)), DATA_W'($random(seed)),
                            DATA_W'($random(seed)), DATA_W'($random(seed)), 1'b0, 1'b0);
            compute_inverse(tbl[i], ea, eb, ec, ed, es);
            tbl[i].sing = es;   // flag of a random row from the model
        end
    endtask

    // --------------------------------------------------
    // checks
    // --------------------------------------------------
    task automatic check_val(input string what, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
        assert (got === exp)
        else
        begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            row_errs++;
        end
    endtask

    task automatic report_test(input string name);
        string verdict;
        if (row_errs == 0)
        begin
            pass_cnt++;
            verdict = "ok";
        end
        else
        begin
            fail_cnt++;
            verdict = "failed";
        end
        $display("test %s: %s", name, verdict);
    endtask

    task automatic run_row(input int idx);
        row_t              r;
        int                lat;
        logic [DATA_W-1:0] ea, eb, ec, ed;
        logic              es;
        r        = tbl[idx];
        row_errs = 0;
        compute_inverse(r, ea, eb, ec, ed, es);
        @(negedge clk_i);
        a_i     = r.a;      // held until ready
        b_i     = r.b;
        c_i     = r.c;
        d_i     = r.d;
        start_i = 1'b1;
        @(negedge clk_i);   // edge k is behind us
        start_i = 1'b0;
        lat     = 0;
        check_val("ready_o after start", DATA_W'(ready_o), '0);
        while (!ready_o)
        begin
            @(negedge clk_i);
            lat++;
            start_i = (r.mid_start && lat == 1);    // sampled in DET, ignored
        end
        start_i = 1'b0;
        check_val("latency", DATA_W'(lat), DATA_W'(LATENCY));
        check_val("a_o", a_o, ea);
        check_val("b_o", b_o, eb);
        check_val("c_o", c_o, ec);
        check_val("d_o", d_o, ed);
        check_val("singular_o", DATA_W'(singular_o), DATA_W'(r.sing));
        report_test($sformatf("%0d [%h %h; %h %h]", idx, r.a, r.b, r.c, r.d));
    endtask

    // --------------------------------------------------
    // clock and watchdog
    // --------------------------------------------------
    initial
    begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    initial
    begin
        cycles = 0;
        while (cycles < LIMIT)
        begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: ready_o did not come within %0d cycles", LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        rstn_i   = 1'b0;
        start_i  = 1'b0;
        a_i      = '0;
        b_i      = '0;
        c_i      = '0;
        d_i      = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        build_table();
        repeat (10) @(negedge clk_i);
        rstn_i = 1'b1;
        @(negedge clk_i);
        row_errs = 0;       // idle state after reset
        check_val("ready_o", DATA_W'(ready_o), '0);
        check_val("singular_o", DATA_W'(singular_o), '0);
        check_val("a_o", a_o, '0);
        check_val("b_o", b_o, '0);
        check_val("c_o", c_o, '0);
        check_val("d_o", d_o, '0);
        report_test("reset");
        for (int i = 0; i < N_ROWS; i++)
            run_row(i);     // rows after the first start from READY
        $display("tests %0d, passed %0d, failed %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
